// File: source/div_pkg.sv
package div_pkg;

    // ******************************
    // widths
    // ******************************
    localparam int div_width     = 32;
    localparam int div_steps     = div_width;  // one quotient bit per step.
    localparam int div_cnt_width = 6;

    // ******************************
    // encodings
    // ******************************
    typedef enum logic {
        div_op_unsigned = 1'b0,
        div_op_signed   = 1'b1
    } div_op_e;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_run  = 2'd1,
        st_hold = 2'd2
    } div_core_state_e;

    // ******************************
    // payloads between the stages
    // ******************************
    typedef struct packed {
        div_op_e                op;
        logic [div_width-1:0]   dividend;
        logic [div_width-1:0]   divisor;
    } div_req_t;

    typedef struct packed {
        logic [div_width-1:0]   dividend_abs;
        logic [div_width-1:0]   divisor_abs;
        logic                   quot_neg;
        logic                   rem_neg;
    } div_work_t;

    typedef struct packed {
        logic [div_width-1:0]   quot_mag;
        logic [div_width-1:0]   rem_mag;
        logic                   quot_neg;
        logic                   rem_neg;
    } div_raw_t;

    typedef struct packed {
        logic [div_width-1:0]   quotient;
        logic [div_width-1:0]   remainder;
    } div_result_t;

endpackage

// File: source/div_operand_prep.sv
`timescale 1ns/1ps

module div_operand_prep import div_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_req,
    input  div_req_t  in_data,
    output logic      in_ack,
    output logic      work_req,
    output div_work_t work_data,
    input  logic      work_ack
);

    logic                 dividend_sign;
    logic                 divisor_sign;
    logic [div_width-1:0] dividend_abs;
    logic [div_width-1:0] divisor_abs;
    logic                 accept;
    div_work_t            work_next;

    // ******************************
    // operand conditioning
    // ******************************
    // sign bits only count for signed ops.
    assign dividend_sign = (in_data.op == div_op_signed) && in_data.dividend[div_width-1];
    assign divisor_sign  = (in_data.op == div_op_signed) && in_data.divisor[div_width-1];

    assign dividend_abs = dividend_sign ? (~in_data.dividend + 1'b1) : in_data.dividend;
    assign divisor_abs  = divisor_sign ? (~in_data.divisor + 1'b1) : in_data.divisor;

    always_comb begin
        work_next.dividend_abs = dividend_abs;
        work_next.divisor_abs  = divisor_abs;
        work_next.quot_neg     = dividend_sign ^ divisor_sign;
        work_next.rem_neg      = dividend_sign;  // remainder follows the dividend.
    end

    // ******************************
    // handshakes
    // ******************************
    // the buffer is full while work_req is high; the core must also have
    // dropped its ack from the previous transfer before a new req goes out.
    assign accept = in_req && !in_ack && !work_req && !work_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack <= 1'b0;
        end else if (accept) begin
            in_ack <= 1'b1;
        end else if (in_ack && !in_req) begin
            in_ack <= 1'b0;  // phase four on the request port.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            work_req <= 1'b0;
        end else if (accept) begin
            work_req <= 1'b1;
        end else if (work_req && work_ack) begin
            work_req <= 1'b0;  // core has captured the entry, buffer is free.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            work_data <= work_next;
        end
    end

endmodule

// File: source/div_iter_core.sv
`timescale 1ns/1ps

module div_iter_core import div_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      work_req,
    input  div_work_t work_data,
    output logic      work_ack,
    output logic      raw_req,
    output div_raw_t  raw_data,
    input  logic      raw_ack
);

    div_core_state_e            state;
    logic [div_cnt_width-1:0]   cnt;
    logic [2*div_width-1:0]     prem;      // upper half is the running remainder.
    logic [div_width-1:0]       divisor_r;
    logic [div_width-1:0]       quot;
    logic                       quot_neg_r;
    logic                       rem_neg_r;

    logic                       start;
    logic                       last_step;
    logic [div_width:0]         trial_hi;
    logic [div_width+1:0]       trial_diff;
    logic                       q_bit;
    logic [div_width-1:0]       next_hi;

    assign start     = (state == st_idle) && work_req && !work_ack;
    assign last_step = (cnt == div_cnt_width'(div_steps - 1));

    // ******************************
    // one restoring step
    // ******************************
    // the shifted remainder can be one bit wider than the divisor.
    assign trial_hi   = prem[2*div_width-1:div_width-1];
    assign trial_diff = {1'b0, trial_hi} - {2'b00, divisor_r};
    assign q_bit      = !trial_diff[div_width+1];  // keep the difference when not negative.
    assign next_hi    = q_bit ? trial_diff[div_width-1:0] : trial_hi[div_width-1:0];

    always_ff @(posedge clk) begin
        if (start) begin
            prem       <= {{div_width{1'b0}}, work_data.dividend_abs};
            divisor_r  <= work_data.divisor_abs;
            quot       <= '0;
            quot_neg_r <= work_data.quot_neg;
            rem_neg_r  <= work_data.rem_neg;
        end else if (state == st_run) begin
            prem <= {next_hi, prem[div_width-2:0], 1'b0};
            quot <= {quot[div_width-2:0], q_bit};
        end
    end

    // ******************************
    // control
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            cnt      <= '0;
            work_ack <= 1'b0;
            raw_req  <= 1'b0;
        end else begin
            if (start) begin
                work_ack <= 1'b1;
            end else if (work_ack && !work_req) begin
                work_ack <= 1'b0;
            end

            case (state)
                st_idle: begin
                    if (start) begin
                        cnt   <= '0;
                        state <= st_run;
                    end
                end
                st_run: begin
                    cnt <= cnt + 1'b1;
                    if (last_step) begin
                        state   <= st_hold;
                        raw_req <= 1'b1;
                    end
                end
                st_hold: begin
                    if (raw_req && raw_ack) begin
                        raw_req <= 1'b0;
                    end else if (!raw_req && !raw_ack) begin
                        state <= st_idle;  // full four-phase cycle done.
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_comb begin
        raw_data.quot_mag = quot;
        raw_data.rem_mag  = prem[2*div_width-1:div_width];
        raw_data.quot_neg = quot_neg_r;
        raw_data.rem_neg  = rem_neg_r;
    end

    // ******************************
    // assertions
    // ******************************
    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        cnt <= div_cnt_width'(div_steps));

    a_raw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        $past(raw_req) && raw_req |-> $stable(raw_data));

    a_ack_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(work_ack) |-> $past(state) == st_idle);

endmodule

// File: source/div_result_fix.sv
`timescale 1ns/1ps

module div_result_fix import div_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        raw_req,
    input  div_raw_t    raw_data,
    output logic        raw_ack,
    output logic        out_req,
    output div_result_t out_data,
    input  logic        out_ack
);

    logic        out_free;
    logic        take;
    div_result_t fixed;

    // ******************************
    // sign correction
    // ******************************
    always_comb begin
        if (raw_data.quot_neg) begin
            fixed.quotient = ~raw_data.quot_mag + 1'b1;
        end else begin
            fixed.quotient = raw_data.quot_mag;
        end
        if (raw_data.rem_neg) begin
            fixed.remainder = ~raw_data.rem_mag + 1'b1;
        end else begin
            fixed.remainder = raw_data.rem_mag;
        end
    end

    // ******************************
    // handshakes
    // ******************************
    // free only after the consumer has completed its side of the exchange.
    assign out_free = !out_req && !out_ack;
    assign take     = raw_req && !raw_ack && out_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raw_ack <= 1'b0;
        end else if (take) begin
            raw_ack <= 1'b1;
        end else if (raw_ack && !raw_req) begin
            raw_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_req <= 1'b0;
        end else if (take) begin
            out_req <= 1'b1;
        end else if (out_req && out_ack) begin
            out_req <= 1'b0;  // result taken.
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= fixed;
        end
    end

    // ******************************
    // assertions
    // ******************************
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req && $stable(out_data));

endmodule

// File: source/div_unit_top.sv
`timescale 1ns/1ps

module div_unit_top import div_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_req,
    input  div_req_t    in_data,
    output logic        in_ack,
    output logic        out_req,
    output div_result_t out_data,
    input  logic        out_ack
);

    // ******************************
    // inter-stage links
    // ******************************
    logic      work_req;
    div_work_t work_data;
    logic      work_ack;

    logic      raw_req;
    div_raw_t  raw_data;
    logic      raw_ack;

    // absolute values and sign flags.
    div_operand_prep u_operand_prep (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .in_data   (in_data),
        .in_ack    (in_ack),
        .work_req  (work_req),
        .work_data (work_data),
        .work_ack  (work_ack)
    );

    // 32 step restoring divide.
    div_iter_core u_iter_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .work_req  (work_req),
        .work_data (work_data),
        .work_ack  (work_ack),
        .raw_req   (raw_req),
        .raw_data  (raw_data),
        .raw_ack   (raw_ack)
    );

    // signs applied, result held for the consumer.
    div_result_fix u_result_fix (
        .clk       (clk),
        .rst_n     (rst_n),
        .raw_req   (raw_req),
        .raw_data  (raw_data),
        .raw_ack   (raw_ack),
        .out_req   (out_req),
        .out_data  (out_data),
        .out_ack   (out_ack)
    );

endmodule

// File: verif/tb_div_unit.sv
`timescale 1ns/1ps

module tb_div_unit import div_pkg::*; ();

    localparam int num_random     = 260;
    localparam int timeout_cycles = 40000;  // about 300 ops at under 80 cycles each.

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_req;
    div_req_t    in_data;
    logic        in_ack;
    logic        out_req;
    div_result_t out_data;
    logic        out_ack;

    div_result_t exp_q[$];
    div_result_t exp_head;
    int          exp_count;
    int          sent_count;
    int          result_count;
    int          error_count;
    int          cycle_count;

    div_unit_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

    always #2 clk = ~clk;

    // ******************************
    // reference model
    // ******************************
    function automatic div_result_t model_result(div_req_t r);
        logic        a_neg;
        logic        b_neg;
        logic [31:0] a_mag;
        logic [31:0] b_mag;
        logic [31:0] q_mag;
        logic [31:0] r_mag;
        div_result_t res;
        a_neg = (r.op == div_op_signed) && r.dividend[31];
        b_neg = (r.op == div_op_signed) && r.divisor[31];
        a_mag = a_neg ? -r.dividend : r.dividend;
        b_mag = b_neg ? -r.divisor : r.divisor;
        if (b_mag == 32'd0) begin
            q_mag = 32'hffff_ffff;
            r_mag = a_mag;
        end else begin
            q_mag = a_mag / b_mag;
            r_mag = a_mag % b_mag;
        end
        res.quotient  = (a_neg ^ b_neg) ? -q_mag : q_mag;  // truncation toward zero.
        res.remainder = a_neg ? -r_mag : r_mag;
        if (r.op == div_op_signed && r.dividend == 32'h8000_0000 &&
            r.divisor == 32'hffff_ffff) begin
            res.quotient  = 32'h8000_0000;
            res.remainder = 32'd0;
        end
        return res;
    endfunction

    function automatic void refresh_head();
        exp_count = exp_q.size();
        if (exp_q.size() > 0) begin
            exp_head = exp_q[0];
        end
    endfunction

    // ******************************
    // request driver and result responder
    // ******************************
    task automatic send_request(input div_op_e op, input logic [31:0] a, input logic [31:0] b);
        div_req_t r;
        int       hold;
        r.op       = op;
        r.dividend = a;
        r.divisor  = b;
        in_data = r;
        in_req  = 1'b1;
        @(posedge clk);
        #1;
        while (!in_ack) begin
            @(posedge clk);
            #1;
        end
        exp_q.push_back(model_result(r));
        refresh_head();
        sent_count++;
        hold = $urandom_range(2, 0);
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        in_req = 1'b0;  // phase three after a short random hold.
        @(posedge clk);
        #1;
        while (in_ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic answer_results();
        int delay;
        forever begin
            @(posedge clk);
            #1;
            if (out_req && !out_ack) begin
                delay = $urandom_range(5, 0);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                out_ack = 1'b1;
                while (out_req) begin
                    @(posedge clk);
                    #1;
                end
                out_ack = 1'b0;
                void'(exp_q.pop_front());
                refresh_head();
                result_count++;
            end
        end
    endtask

    // ******************************
    // stimulus
    // ******************************
    task automatic run_directed();
        send_request(div_op_unsigned, 32'd100, 32'd7);  // first op after reset.
        send_request(div_op_unsigned, 32'd5, 32'd9);
        send_request(div_op_unsigned, 32'hffff_ffff, 32'h8000_0000);
        send_request(div_op_unsigned, 32'h8000_0001, 32'd3);
        send_request(div_op_unsigned, 32'h1234_5678, 32'hffff_fff0);
        send_request(div_op_signed, 32'd7, 32'd2);
        send_request(div_op_signed, 32'hffff_fff9, 32'd2);
        send_request(div_op_signed, 32'd7, 32'hffff_fffe);
        send_request(div_op_signed, 32'hffff_fff9, 32'hffff_fffe);
        send_request(div_op_signed, 32'h8765_4321, 32'h0000_1234);
        send_request(div_op_unsigned, 32'hdead_beef, 32'd0);
        send_request(div_op_signed, 32'd1234, 32'd0);
        send_request(div_op_signed, 32'hffff_fb2e, 32'd0);
        send_request(div_op_signed, 32'h8000_0000, 32'hffff_ffff);
        send_request(div_op_unsigned, 32'h8000_0000, 32'hffff_ffff);
        send_request(div_op_signed, 32'h8000_0000, 32'd1);
    endtask

    task automatic run_random();
        int          i;
        int          kind;
        div_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        for (i = 0; i < num_random; i++) begin
            op   = div_op_e'($urandom_range(1, 0));
            kind = $urandom_range(3, 0);
            a    = $urandom;
            b    = $urandom;
            case (kind)
                1: b = $urandom_range(255, 1);  // large quotients.
                2: a = $urandom_range(1000, 0);  // mostly dividend below divisor.
                3: b = ($urandom_range(7, 0) == 0) ? 32'd0 : -($urandom_range(300, 1));
                default: ;
            endcase
            send_request(op, a, b);
        end
    endtask

    initial begin
        void'($urandom(32'hef77627d));
        rst_n        = 1'b0;
        in_req       = 1'b0;
        in_data      = '0;
        out_ack      = 1'b0;
        exp_head     = '0;
        exp_count    = 0;
        sent_count   = 0;
        result_count = 0;
        error_count  = 0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        fork
            answer_results();
        join_none
        @(posedge clk);
        #1;
        run_directed();
        run_random();
        while (exp_count > 0) begin
            @(posedge clk);
            #1;
        end
        repeat (5) @(posedge clk);
        $display("summary: %0d requests, %0d results, %0d errors",
                 sent_count, result_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("the run did not finish within %0d cycles and was stopped", timeout_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ******************************
    // checks
    // ******************************
    check_result: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> out_data == exp_head)
    else begin
        error_count++;
        $display("[FAIL] %0t: got q=%h r=%h, expected q=%h r=%h", $time,
                 out_data.quotient, out_data.remainder, exp_head.quotient, exp_head.remainder);
    end

    check_result_expected: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> exp_count > 0)
    else begin
        error_count++;
        $display("a result appeared at %0t with no request outstanding", $time);
    end

    check_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req && $stable(out_data))
    else begin
        error_count++;
        $display("out_req or out_data changed before out_ack at %0t", $time);
    end

    check_out_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> !$past(out_ack))
    else begin
        error_count++;
        $display("out_req rose while out_ack was still high at %0t", $time);
    end

    check_in_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
        in_req && in_ack |=> in_ack)
    else begin
        error_count++;
        $display("in_ack fell while in_req was still high at %0t", $time);
    end

    check_in_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        !in_req && !in_ack |=> !in_ack)
    else begin
        error_count++;
        $display("in_ack rose without a request at %0t", $time);
    end

    check_in_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        !in_req && in_ack |=> !in_ack)
    else begin
        error_count++;
        $display("in_ack did not fall one cycle after in_req at %0t", $time);
    end

    check_reset_state: assert property (@(posedge clk)
        !rst_n || $rose(rst_n) |-> !in_ack && !out_req)
    else begin
        error_count++;
        $display("in_ack or out_req was high around reset at %0t", $time);
    end

endmodule

// File: verilog.f
source/div_pkg.sv
source/div_operand_prep.sv
source/div_iter_core.sv
source/div_result_fix.sv
source/div_unit_top.sv
verif/tb_div_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the divide unit testbench with Verilator, runs it and checks the result.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_div_unit \
    --Mdir obj_dir \
    -o tb_div_unit \
    -f verilog.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_div_unit)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    echo "run_sim: passed"
    exit 0
else
    echo "run_sim: failed"
    exit 1
fi
